/* build.f */
verilog/pitaya_pkg.sv
verilog/adc_frontend.sv
verilog/fir_first_order.sv
verilog/fir_third_order.sv
verilog/p_controller.sv
verilog/ramp_gen.sv
verilog/dac_backend.sv
verilog/pitaya_core_top.sv
test/tb_pitaya_core.sv

/* test/tb_pitaya_core.sv */
/* Directed testbench for the ADC to DAC path with an integer cycle model.
   Inputs change on the falling edge. Outputs are compared on the falling edge. */

module tb_pitaya_core;

  logic                  adc_clk;
  logic                  rst_n_i;
  pitaya_pkg::raw_adc_t  adc_a, adc_b;
  logic                  loop_en;
  pitaya_pkg::sample_t   setpoint_a, setpoint_b;
  pitaya_pkg::gain_t     kp_a, kp_b;
  logic                  ramp_en_a, ramp_en_b;
  pitaya_pkg::sample_t   step_a, step_b;
  pitaya_pkg::sample_t   filt_a, filt_b;
  pitaya_pkg::dac_code_t dac_a, dac_b;

  integer seed;
  int     cycles = 0;
  int     cycle_limit;

  // Model state
  integer m_adc_a, m_adc_b;    // Front end registers
  integer m_d1, m_d2, m_d3;    // Channel A delay line
  integer m_xb;                // Channel B previous sample
  integer m_filt_a, m_filt_b;
  integer m_ctrl_a, m_ctrl_b;
  integer m_ramp_a, m_ramp_b;
  integer m_loop_a, m_loop_b;  // Saturated sums
  integer m_dac_a, m_dac_b;    // DAC codes

  pitaya_core_top uut (
    .adc_clk      (adc_clk   ),
    .rst_n_i      (rst_n_i   ),
    .adc_a_i      (adc_a     ),
    .adc_b_i      (adc_b     ),
    .loop_en_i    (loop_en   ),
    .setpoint_a_i (setpoint_a),
    .setpoint_b_i (setpoint_b),
    .kp_a_i       (kp_a      ),
    .kp_b_i       (kp_b      ),
    .ramp_en_a_i  (ramp_en_a ),
    .ramp_en_b_i  (ramp_en_b ),
    .step_a_i     (step_a    ),
    .step_b_i     (step_b    ),
    .filt_a_o     (filt_a    ),
    .filt_b_o     (filt_b    ),
    .dac_a_o      (dac_a     ),
    .dac_b_o      (dac_b     )
  );

  initial begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;  // Period 40
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference arithmetic
  ////////////////////////////////////////////////////////////////////////////

  // Top bit kept and low 13 bits inverted is the same as 8191 - x
  function automatic integer adc_value(input pitaya_pkg::raw_adc_t raw);
    integer code;
    code = raw >> pitaya_pkg::ADC_DROP;
    return 8191 - code;
  endfunction

  function automatic pitaya_pkg::raw_adc_t raw_word(input integer s, input integer lsb);
    integer code;
    code = 8191 - s;
    return (code << 2) | (lsb & 3);  // Unused LSBs carry junk
  endfunction

  function automatic integer sat14(input integer v);
    if (v > 8191)
      return 8191;
    else if (v < -8192)
      return -8192;
    return v;
  endfunction

  function automatic integer wrap14(input integer v);
    integer w;
    w = v & 16383;
    if (w > 8191)
      w = w - 16384;  // Back to signed
    return w;
  endfunction

  function automatic integer p_term(input integer sp, input integer meas, input integer kp);
    return sat14(((sp - meas) * kp) >>> pitaya_pkg::KP_SHIFT);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Cycle model advanced on the same edges as the DUT
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      m_adc_a  = 0;
      m_adc_b  = 0;
      m_d1     = 0;
      m_d2     = 0;
      m_d3     = 0;
      m_xb     = 0;
      m_filt_a = 0;
      m_filt_b = 0;
      m_ctrl_a = 0;
      m_ctrl_b = 0;
      m_ramp_a = 0;
      m_ramp_b = 0;
      m_loop_a = 0;
      m_loop_b = 0;
      m_dac_a  = 8191;  // Code of zero
      m_dac_b  = 8191;
    end else begin
      // Sums from the state before this edge
      m_loop_a = sat14(m_ramp_a + m_ctrl_a);
      m_loop_b = sat14(m_ramp_b + m_ctrl_b);
      m_dac_a  = 8191 - m_loop_a;
      m_dac_b  = 8191 - m_loop_b;
      if (ramp_en_a)
        m_ramp_a = wrap14(m_ramp_a + step_a);
      if (ramp_en_b)
        m_ramp_b = wrap14(m_ramp_b + step_b);
      m_ctrl_a = p_term(setpoint_a, m_filt_a, kp_a);  // Old filter outputs
      m_ctrl_b = p_term(setpoint_b, m_filt_b, kp_b);
      m_filt_a = (m_adc_a + 3 * (m_d1 + m_d2) + m_d3) >>> 3;
      m_filt_b = (m_adc_b + m_xb) >>> 1;
      m_d3 = m_d2;
      m_d2 = m_d1;
      m_d1 = m_adc_a;
      m_xb = m_adc_b;
      m_adc_a = loop_en ? m_loop_a : adc_value(adc_a);
      m_adc_b = loop_en ? m_loop_b : adc_value(adc_b);
    end
  end

  // Limit is about five times the length of the test sequence
  always @(posedge adc_clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
      abort_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "Run stopped on failure");
  endtask

  task automatic check_sample(input string port, input pitaya_pkg::sample_t exp,
                              input pitaya_pkg::sample_t act);
    if (act !== exp) begin
      $display("** Error at time %0t: %s expected %0d, got %0d", $time, port, exp, act);
      abort_run();
    end
  endtask

  task automatic check_code(input string port, input pitaya_pkg::dac_code_t exp,
                            input pitaya_pkg::dac_code_t act);
    if (act !== exp) begin
      $display("** Error at time %0t: %s expected 0x%h, got 0x%h", $time, port, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_outputs();
    check_sample("filt_a_o", pitaya_pkg::sample_t'(m_filt_a), filt_a);
    check_sample("filt_b_o", pitaya_pkg::sample_t'(m_filt_b), filt_b);
    check_code("dac_a_o", pitaya_pkg::dac_code_t'(m_dac_a), dac_a);
    check_code("dac_b_o", pitaya_pkg::dac_code_t'(m_dac_b), dac_b);
  endtask

  // Wait for the falling edge and compare against the model
  task automatic next_cycle();
    @(negedge adc_clk);
    compare_outputs();
  endtask

  task automatic check_idle();
    check_sample("filt_a_o", '0, filt_a);
    check_sample("filt_b_o", '0, filt_b);
    check_code("dac_a_o", 14'h1FFF, dac_a);  // Code of zero
    check_code("dac_b_o", 14'h1FFF, dac_b);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_state_test();
    repeat (5) begin
      @(negedge adc_clk);
      check_idle();
    end
    rst_n_i = 1'b1;
    next_cycle();  // First edge out of reset
    check_idle();
  endtask

  task automatic filter_step_test();
    integer levels [3];
    levels = '{100, -3000, 4001};
    foreach (levels[i]) begin
      adc_a = raw_word(levels[i], i);
      adc_b = raw_word(-levels[i], 3 - i);
      repeat (8) begin
        next_cycle();
        check_code("dac_a_o", 14'h1FFF, dac_a);  // Gains zero and ramps off
        check_code("dac_b_o", 14'h1FFF, dac_b);
      end
      // Both filters have DC gain one
      check_sample("filt_a_o", pitaya_pkg::sample_t'(levels[i]), filt_a);
      check_sample("filt_b_o", pitaya_pkg::sample_t'(-levels[i]), filt_b);
    end
  endtask

  // Measurements held at 1000 and -1500
  task automatic controller_case(input integer sp_a, input integer gain_a,
                                 input integer sp_b, input integer gain_b,
                                 input integer exp_a, input integer exp_b);
    setpoint_a = sp_a;
    setpoint_b = sp_b;
    kp_a       = gain_a;
    kp_b       = gain_b;
    repeat (8) next_cycle();
    check_code("dac_a_o", pitaya_pkg::dac_code_t'(8191 - exp_a), dac_a);
    check_code("dac_b_o", pitaya_pkg::dac_code_t'(8191 - exp_b), dac_b);
  endtask

  task automatic controller_test();
    adc_a = raw_word(1000, 1);
    adc_b = raw_word(-1500, 2);
    controller_case(2000, 16, 500, 32, 1000, 4000);      // Unity and double gain
    controller_case(-3000, 40, 7000, 255, -8192, 8191);  // Clip low and clip high
    controller_case(8000, 200, -8000, 100, 8191, -8192);
    controller_case(1003, 7, -1501, 3, 1, -1);           // Shift rounds down
    kp_a = 0;
    kp_b = 0;
    repeat (3) next_cycle();
  endtask

  task automatic ramp_test();
    integer acc;
    acc       = 0;
    step_a    = 3000;  // Wraps on the third step
    step_b    = 1234;
    ramp_en_a = 1'b1;
    ramp_en_b = 1'b0;
    repeat (12) begin
      next_cycle();
      check_code("dac_a_o", pitaya_pkg::dac_code_t'(8191 - acc), dac_a);
      check_code("dac_b_o", 14'h1FFF, dac_b);
      acc = wrap14(acc + 3000);
    end
    ramp_en_a = 1'b0;
    repeat (5) begin
      next_cycle();
      check_code("dac_a_o", pitaya_pkg::dac_code_t'(8191 - acc), dac_a);  // Held
    end
  endtask

  task automatic loopback_test();
    integer held_a, held_b;
    integer n;
    step_a    = -1500;
    step_b    = 700;
    ramp_en_a = 1'b1;
    ramp_en_b = 1'b1;
    repeat (4) next_cycle();
    ramp_en_a = 1'b0;
    ramp_en_b = 1'b0;
    held_a    = m_ramp_a;
    held_b    = m_ramp_b;
    loop_en   = 1'b1;
    for (n = 0; n < 12; n++) begin
      adc_a = $random(seed);  // Must be ignored
      adc_b = $random(seed);
      next_cycle();
      if (n >= 6) begin
        check_sample("filt_a_o", pitaya_pkg::sample_t'(held_a), filt_a);
        check_sample("filt_b_o", pitaya_pkg::sample_t'(held_b), filt_b);
      end
    end
    loop_en = 1'b0;
  endtask

  task automatic random_stream_test();
    integer n;
    setpoint_a = 500;
    setpoint_b = -700;
    kp_a       = 3;
    kp_b       = 12;
    for (n = 0; n < 200; n++) begin
      adc_a = $random(seed);
      adc_b = $random(seed);
      next_cycle();
    end
    repeat (6) next_cycle();  // Drain the pipeline
  endtask

  initial begin
    seed        = 75296;
    cycle_limit = 1500;
    rst_n_i     = 1'b0;
    adc_a       = raw_word(0, 0);
    adc_b       = raw_word(0, 0);
    loop_en     = 1'b0;
    setpoint_a  = '0;
    setpoint_b  = '0;
    kp_a        = '0;
    kp_b        = '0;
    ramp_en_a   = 1'b0;
    ramp_en_b   = 1'b0;
    step_a      = '0;
    step_b      = '0;

    reset_state_test();
    filter_step_test();
    controller_test();
    ramp_test();
    loopback_test();
    random_stream_test();

    $display("NO ERRORS");
    $finish;
  end

endmodule

/* verilog/adc_frontend.sv */
/* ADC input stage for both channels, one register stage.
   Raw words are negative-slope offset binary, LSBs [1:0] are ignored. */

module adc_frontend (
  input  logic                 rst_n_i,    // Async reset, active low
  input  logic                 adc_clk,
  input  pitaya_pkg::raw_adc_t adc_a_i,    // Raw channel A
  input  pitaya_pkg::raw_adc_t adc_b_i,    // Raw channel B
  input  logic                 loop_en_i,  // Take DAC sums instead of ADC
  input  pitaya_pkg::sample_t  loop_a_i,   // Saturated sum A, combinational
  input  pitaya_pkg::sample_t  loop_b_i,
  output pitaya_pkg::sample_t  adc_a_o,
  output pitaya_pkg::sample_t  adc_b_o
);

  // Top bit kept, lower bits flipped
  function automatic pitaya_pkg::sample_t to_twos(input pitaya_pkg::raw_adc_t raw);
    logic [pitaya_pkg::SAMPLE_W-1:0] code;
    code = raw[pitaya_pkg::SAMPLE_W+pitaya_pkg::ADC_DROP-1:pitaya_pkg::ADC_DROP];
    return {code[pitaya_pkg::SAMPLE_W-1], ~code[pitaya_pkg::SAMPLE_W-2:0]};
  endfunction

  pitaya_pkg::sample_t sel_a, sel_b;  // Before the register

  // Loopback mux
  assign sel_a = loop_en_i ? loop_a_i : to_twos(adc_a_i);
  assign sel_b = loop_en_i ? loop_b_i : to_twos(adc_b_i);

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= sel_a;
      adc_b_o <= sel_b;
    end
  end

endmodule

/* verilog/dac_backend.sv */
/* Output stage, ramp plus controller with saturation to 14 bits.
   Loopback outputs are combinational, the DAC codes are registered. */

module dac_backend (
  input  logic                  rst_n_i,
  input  logic                  adc_clk,
  input  pitaya_pkg::sample_t   gen_a_i,   // Ramp A
  input  pitaya_pkg::sample_t   gen_b_i,   // Ramp B
  input  pitaya_pkg::sample_t   ctrl_a_i,  // Controller A
  input  pitaya_pkg::sample_t   ctrl_b_i,  // Controller B
  output pitaya_pkg::sample_t   loop_a_o,  // Saturated sum, same cycle
  output pitaya_pkg::sample_t   loop_b_o,
  output pitaya_pkg::dac_code_t dac_a_o,   // Negative-slope code
  output pitaya_pkg::dac_code_t dac_b_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Sum and saturate
  ////////////////////////////////////////////////////////////////////////////

  function automatic pitaya_pkg::sample_t sat_sum(input pitaya_pkg::sample_t a,
                                                  input pitaya_pkg::sample_t b);
    logic signed [pitaya_pkg::SAMPLE_W:0] sum;
    sum = a + b;  // 15 bits
    // Top two bits differ on overflow
    if (sum[pitaya_pkg::SAMPLE_W] ^ sum[pitaya_pkg::SAMPLE_W-1])
      return sum[pitaya_pkg::SAMPLE_W] ? pitaya_pkg::SAMPLE_MIN : pitaya_pkg::SAMPLE_MAX;
    else
      return sum[pitaya_pkg::SAMPLE_W-1:0];
  endfunction

  // Two's complement to negative-slope code
  function automatic pitaya_pkg::dac_code_t to_dac(input pitaya_pkg::sample_t s);
    return {s[pitaya_pkg::SAMPLE_W-1], ~s[pitaya_pkg::SAMPLE_W-2:0]};
  endfunction

  assign loop_a_o = sat_sum(gen_a_i, ctrl_a_i);
  assign loop_b_o = sat_sum(gen_b_i, ctrl_b_i);

  ////////////////////////////////////////////////////////////////////////////
  // DAC registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // Code of a zero sample, 0x1FFF
      dac_a_o <= {1'b0, {(pitaya_pkg::SAMPLE_W-1){1'b1}}};
      dac_b_o <= {1'b0, {(pitaya_pkg::SAMPLE_W-1){1'b1}}};
    end else begin
      dac_a_o <= to_dac(loop_a_o);
      dac_b_o <= to_dac(loop_b_o);
    end
  end

endmodule

/* verilog/fir_first_order.sv */
/* Two-tap moving average, y = (x[n] + x[n-1]) / 2.
   Result rounds toward minus infinity, one register stage. */

module fir_first_order (
  input  logic                rst_n_i,
  input  logic                adc_clk,
  input  pitaya_pkg::sample_t x_i,  // New sample every cycle
  output pitaya_pkg::sample_t y_o   // Registered average
);

  pitaya_pkg::sample_t x_d;  // Previous input

  logic signed [pitaya_pkg::SAMPLE_W:0] sum;  // One bit of headroom
  logic signed [pitaya_pkg::SAMPLE_W:0] half;

  assign sum  = x_i + x_d;
  assign half = sum >>> 1;  // Arithmetic, keeps sign

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      x_d <= '0;
      y_o <= '0;
    end else begin
      x_d <= x_i;
      // Always back in range after the halving
      y_o <= half[pitaya_pkg::SAMPLE_W-1:0];
    end
  end

endmodule

/* verilog/fir_third_order.sv */
/* Four-tap binomial low-pass, weights 1-3-3-1 over 8.
   DC gain is one, output is registered once after the delay line input. */

module fir_third_order (
  input  logic                rst_n_i,
  input  logic                adc_clk,
  input  pitaya_pkg::sample_t x_i,
  output pitaya_pkg::sample_t y_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Delay line
  ////////////////////////////////////////////////////////////////////////////

  pitaya_pkg::sample_t d1, d2, d3;  // x[n-1], x[n-2], x[n-3]

  ////////////////////////////////////////////////////////////////////////////
  // Weighted sum
  ////////////////////////////////////////////////////////////////////////////

  // Pairs of equal weight summed first
  logic signed [pitaya_pkg::SAMPLE_W:0]   outer;  // x[n] + x[n-3]
  logic signed [pitaya_pkg::SAMPLE_W:0]   inner;  // x[n-1] + x[n-2]
  logic signed [pitaya_pkg::SAMPLE_W+3:0] acc;    // 8x full scale fits
  logic signed [pitaya_pkg::SAMPLE_W+3:0] acc_sh;

  assign outer  = x_i + d3;
  assign inner  = d1 + d2;
  assign acc    = pitaya_pkg::FIR3_C1 * outer + pitaya_pkg::FIR3_C2 * inner;
  assign acc_sh = acc >>> pitaya_pkg::FIR3_SHIFT;  // Divide by 8

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      d1  <= '0;
      d2  <= '0;
      d3  <= '0;
      y_o <= '0;
    end else begin
      d1  <= x_i;
      d2  <= d1;
      d3  <= d2;
      y_o <= acc_sh[pitaya_pkg::SAMPLE_W-1:0];  // Top bits are sign copies
    end
  end

endmodule

/* verilog/p_controller.sv */
/* Proportional controller, ctrl = sat((setpoint - meas) * kp >> KP_SHIFT).
   Gain is unsigned, so kp = 16 gives unity. One register stage. */

module p_controller (
  input  logic                rst_n_i,
  input  logic                adc_clk,
  input  pitaya_pkg::sample_t meas_i,      // Filtered measurement
  input  pitaya_pkg::sample_t setpoint_i,
  input  pitaya_pkg::gain_t   kp_i,
  output pitaya_pkg::sample_t ctrl_o       // Registered, saturated
);

  ////////////////////////////////////////////////////////////////////////////
  // Error and product
  ////////////////////////////////////////////////////////////////////////////

  logic signed [pitaya_pkg::SAMPLE_W:0]   err;     // 15 bits, no overflow
  logic signed [8:0]                      kp_s;    // Gain with zero sign bit
  logic signed [pitaya_pkg::SAMPLE_W+9:0] prod;    // 15 x 9 bits
  logic signed [pitaya_pkg::SAMPLE_W+9:0] scaled;
  pitaya_pkg::sample_t                    sat;

  assign err    = setpoint_i - meas_i;
  assign kp_s   = $signed({1'b0, kp_i});
  assign prod   = err * kp_s;
  assign scaled = prod >>> pitaya_pkg::KP_SHIFT;

  ////////////////////////////////////////////////////////////////////////////
  // Saturation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (scaled > pitaya_pkg::SAMPLE_MAX)
      sat = pitaya_pkg::SAMPLE_MAX;  // Clip high
    else if (scaled < pitaya_pkg::SAMPLE_MIN)
      sat = pitaya_pkg::SAMPLE_MIN;  // Clip low
    else
      sat = scaled[pitaya_pkg::SAMPLE_W-1:0];
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i)
      ctrl_o <= '0;
    else
      ctrl_o <= sat;
  end

endmodule

/* verilog/pitaya_core_top.sv */
/* Analog signal path, ADC in to DAC out in four adc_clk cycles.
   Single clock domain, reset is expected to be synchronized outside. */

module pitaya_core_top (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,       // Async, active low
  // ADC
  input  pitaya_pkg::raw_adc_t  adc_a_i,
  input  pitaya_pkg::raw_adc_t  adc_b_i,
  input  logic                  loop_en_i,     // Digital loopback
  // Controller configuration
  input  pitaya_pkg::sample_t   setpoint_a_i,
  input  pitaya_pkg::sample_t   setpoint_b_i,
  input  pitaya_pkg::gain_t     kp_a_i,
  input  pitaya_pkg::gain_t     kp_b_i,
  // Ramp configuration
  input  logic                  ramp_en_a_i,
  input  logic                  ramp_en_b_i,
  input  pitaya_pkg::sample_t   step_a_i,
  input  pitaya_pkg::sample_t   step_b_i,
  // Filtered samples, two cycles after the ADC pins
  output pitaya_pkg::sample_t   filt_a_o,
  output pitaya_pkg::sample_t   filt_b_o,
  // DAC codes
  output pitaya_pkg::dac_code_t dac_a_o,
  output pitaya_pkg::dac_code_t dac_b_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal samples
  ////////////////////////////////////////////////////////////////////////////

  pitaya_pkg::sample_t adc_a, adc_b;    // Front end, stage 1
  pitaya_pkg::sample_t filt_a, filt_b;  // Filters, stage 2
  pitaya_pkg::sample_t ctrl_a, ctrl_b;  // Controllers, stage 3
  pitaya_pkg::sample_t ramp_a, ramp_b;  // Generator outputs
  pitaya_pkg::sample_t loop_a, loop_b;  // Saturated sums back to front end

  assign filt_a_o = filt_a;
  assign filt_b_o = filt_b;

  adc_frontend i_adc (
    .rst_n_i   (rst_n_i  ),
    .adc_clk   (adc_clk  ),
    .adc_a_i   (adc_a_i  ),
    .adc_b_i   (adc_b_i  ),
    .loop_en_i (loop_en_i),
    .loop_a_i  (loop_a   ),
    .loop_b_i  (loop_b   ),
    .adc_a_o   (adc_a    ),
    .adc_b_o   (adc_b    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Filters
  ////////////////////////////////////////////////////////////////////////////

  fir_third_order i_fir_a (.rst_n_i(rst_n_i), .adc_clk(adc_clk), .x_i(adc_a), .y_o(filt_a));
  fir_first_order i_fir_b (.rst_n_i(rst_n_i), .adc_clk(adc_clk), .x_i(adc_b), .y_o(filt_b));

  ////////////////////////////////////////////////////////////////////////////
  // Controllers
  ////////////////////////////////////////////////////////////////////////////

  p_controller i_ctrl_a (
    .rst_n_i    (rst_n_i     ),
    .adc_clk    (adc_clk     ),
    .meas_i     (filt_a      ),
    .setpoint_i (setpoint_a_i),
    .kp_i       (kp_a_i      ),
    .ctrl_o     (ctrl_a      )
  );

  p_controller i_ctrl_b (
    .rst_n_i    (rst_n_i     ),
    .adc_clk    (adc_clk     ),
    .meas_i     (filt_b      ),
    .setpoint_i (setpoint_b_i),
    .kp_i       (kp_b_i      ),
    .ctrl_o     (ctrl_b      )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Ramps and DAC
  ////////////////////////////////////////////////////////////////////////////

  ramp_gen i_ramp_a (.rst_n_i(rst_n_i), .adc_clk(adc_clk), .en_i(ramp_en_a_i),
                     .step_i(step_a_i), .ramp_o(ramp_a));
  ramp_gen i_ramp_b (.rst_n_i(rst_n_i), .adc_clk(adc_clk), .en_i(ramp_en_b_i),
                     .step_i(step_b_i), .ramp_o(ramp_b));

  dac_backend i_dac (
    .rst_n_i  (rst_n_i),
    .adc_clk  (adc_clk),
    .gen_a_i  (ramp_a ),
    .gen_b_i  (ramp_b ),
    .ctrl_a_i (ctrl_a ),
    .ctrl_b_i (ctrl_b ),
    .loop_a_o (loop_a ),  // Loop closes through front end, filter, controller
    .loop_b_o (loop_b ),
    .dac_a_o  (dac_a_o),
    .dac_b_o  (dac_b_o)
  );

endmodule

/* verilog/pitaya_pkg.sv */
/* Shared types and constants of the ADC to DAC signal path.
   Samples are 14-bit two's complement, one per adc_clk cycle, no back-pressure. */

package pitaya_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sample geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int SAMPLE_W = 14;  // Converter resolution
  localparam int ADC_DROP = 2;   // Unused raw LSBs of the 16-bit ADC bus

  // Raw ADC word, the converter code sits in the top bits
  typedef logic [SAMPLE_W+ADC_DROP-1:0] raw_adc_t;

  // Signed sample used everywhere inside the path
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // DAC code, negative-slope offset binary
  typedef logic [SAMPLE_W-1:0] dac_code_t;

  typedef logic [7:0] gain_t;  // Unsigned proportional gain

  // Saturation limits, +8191 and -8192
  localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
  localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

  ////////////////////////////////////////////////////////////////////////////
  // Controller and filter constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int KP_SHIFT = 4;  // Gain of 16 is unity

  // Binomial weights 1-3-3-1, sum 8
  localparam logic signed [3:0] FIR3_C1 = 4'sd1;  // Outer taps
  localparam logic signed [3:0] FIR3_C2 = 4'sd3;  // Inner taps
  localparam int FIR3_SHIFT = 3;  // Divide by weight sum

endpackage

/* verilog/ramp_gen.sv */
/* Wrapping ramp, the accumulator adds step_i each cycle while enabled.
   Wraps modulo 2^14, so the output is a sawtooth from -8192 to +8191. */

module ramp_gen (
  input  logic                rst_n_i,
  input  logic                adc_clk,
  input  logic                en_i,    // Low holds the current value
  input  pitaya_pkg::sample_t step_i,  // Signed step, negative ramps down
  output pitaya_pkg::sample_t ramp_o
);

  pitaya_pkg::sample_t acc;  // Phase accumulator

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc <= '0;
    end else if (en_i) begin
      // Natural 14-bit overflow gives the wrap
      acc <= acc + step_i;
    end
  end

  // Accumulator read directly as a signed sample
  assign ramp_o = acc;

endmodule
